/* source/proximity_pkg.sv */
package proximity_pkg;

	// ------------------------------------------------------------
	// Ranging timing, all in CLOCK_50 cycles
	// ------------------------------------------------------------

	// Echo round trip per millimetre at 343 m/s
	localparam int unsigned CYCLES_PER_MM = 291;
	// 10 us trigger pulse
	localparam int unsigned TRIG_CYCLES = 500;
	// Longest wait from trigger fall to echo rise
	localparam int unsigned ECHO_WAIT_CYCLES = 25000;
	// Quiet time on the shared acoustic channel
	localparam int unsigned PING_GAP_CYCLES = 50000;

	// Distance range
	localparam int unsigned MAX_RANGE_MM = 4000;
	localparam int unsigned DIST_W = 12;

	// Sensors, 0 is front and 1 is back
	localparam int unsigned SENSOR_COUNT = 2;
	localparam int unsigned FRONT_THRESHOLD_MM = 1000;
	localparam int unsigned BACK_THRESHOLD_MM = 500;

	// Counter widths
	localparam int unsigned PING_CNT_W = $clog2(ECHO_WAIT_CYCLES);
	localparam int unsigned MM_SUB_W = $clog2(CYCLES_PER_MM);
	localparam int unsigned GAP_CNT_W = $clog2(PING_GAP_CYCLES);
	localparam int unsigned SENSOR_W = $clog2(SENSOR_COUNT);

	// ------------------------------------------------------------
	// Seven-segment table, active low, bit order g f e d c b a
	// ------------------------------------------------------------
	function automatic logic [6:0] seg7(input logic [3:0] digit);
		case (digit)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0010000;
			// Blank for anything outside BCD
			default: return 7'b1111111;
		endcase
	endfunction

endpackage

/* source/ping_bus_if.sv */
interface ping_bus_if import proximity_pkg::*; ();

	// Ping permission, level held by the arbiter
	logic grant;
	// One-cycle end-of-ping strobe from the ranger
	logic valid;
	// Result, held until the next valid
	logic [DIST_W-1:0] distance_mm;
	// No echo seen, only meaningful with valid
	logic no_echo;

	// Sensor side
	modport ranger (
		input  grant,
		output valid,
		output distance_mm,
		output no_echo
	);

	// Channel owner
	modport arbiter (
		output grant,
		input  valid
	);

	// Result consumers
	modport monitor (
		input valid,
		input distance_mm,
		input no_echo
	);

endinterface

/* source/sonar_range.sv */
module sonar_range import proximity_pkg::*; (
	input  logic CLOCK_50,
	input  logic reset,
	input  logic echo,
	output logic trig,
	ping_bus_if.ranger bus
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_TRIG,
		ST_WAIT,
		ST_MEASURE,
		ST_REPORT
	} state_t;

	state_t state;

	// Grant edge detect
	logic grant_q;
	logic grant_rise;

	// Shared trigger and echo-wait counter
	logic [PING_CNT_W-1:0] cnt;
	logic trig_done;
	logic wait_done;

	// Millimetre counting, sub-counter instead of a divider
	logic [MM_SUB_W-1:0] sub_cnt;
	logic [DIST_W-1:0] mm_cnt;
	logic mm_tick;
	logic mm_full;

	assign grant_rise = bus.grant && !grant_q;
	assign trig_done = (cnt == PING_CNT_W'(TRIG_CYCLES - 1));
	assign wait_done = (cnt == PING_CNT_W'(ECHO_WAIT_CYCLES - 1));
	assign mm_tick = (sub_cnt == MM_SUB_W'(CYCLES_PER_MM - 1));
	assign mm_full = (mm_cnt == DIST_W'(MAX_RANGE_MM));

	// Strobe decoded from state
	assign bus.valid = (state == ST_REPORT);

	// ------------------------------------------------------------
	// Ping sequencer
	// ------------------------------------------------------------
	always_ff @(posedge CLOCK_50 or negedge reset) begin
		if (!reset) begin
			state <= ST_IDLE;
			grant_q <= 1'b0;
			trig <= 1'b0;
			cnt <= '0;
			sub_cnt <= '0;
			mm_cnt <= '0;
		end else begin
			grant_q <= bus.grant;
			case (state)
				ST_IDLE: begin
					// One ping per grant edge
					if (grant_rise) begin
						state <= ST_TRIG;
						trig <= 1'b1;
						cnt <= '0;
					end
				end
				ST_TRIG: begin
					if (trig_done) begin
						state <= ST_WAIT;
						trig <= 1'b0;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_WAIT: begin
					if (echo) begin
						state <= ST_MEASURE;
						sub_cnt <= '0;
						mm_cnt <= '0;
					end else if (wait_done) begin
						// Timed out, nothing in range
						state <= ST_REPORT;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_MEASURE: begin
					// Echo fall or range limit ends the ping
					if (!echo || mm_full) begin
						state <= ST_REPORT;
					end else if (mm_tick) begin
						sub_cnt <= '0;
						mm_cnt <= mm_cnt + 1'b1;
					end else begin
						sub_cnt <= sub_cnt + 1'b1;
					end
				end
				ST_REPORT: begin
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
					trig <= 1'b0;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// Result word, loaded on the way into report
	// ------------------------------------------------------------
	always_ff @(posedge CLOCK_50) begin
		if (state == ST_WAIT && !echo && wait_done) begin
			bus.distance_mm <= DIST_W'(MAX_RANGE_MM);
			bus.no_echo <= 1'b1;
		end else if (state == ST_MEASURE && (!echo || mm_full)) begin
			// Saturated count already equals MAX_RANGE_MM
			bus.distance_mm <= mm_cnt;
			bus.no_echo <= 1'b0;
		end
	end

endmodule

/* source/ping_arbiter.sv */
module ping_arbiter import proximity_pkg::*; (
	input logic CLOCK_50,
	input logic reset,
	ping_bus_if.arbiter bus [SENSOR_COUNT]
);

	// Flattened view of the interface array
	logic [SENSOR_COUNT-1:0] grant_vec;
	logic [SENSOR_COUNT-1:0] valid_vec;

	// Round-robin pointer, front first
	logic [SENSOR_W-1:0] ptr;
	logic [SENSOR_W-1:0] ptr_next;

	// Quiet gap timer
	logic [GAP_CNT_W-1:0] gap_cnt;
	logic gap_done;

	for (genvar i = 0; i < SENSOR_COUNT; i++) begin : g_port
		assign bus[i].grant = grant_vec[i];
		assign valid_vec[i] = bus[i].valid;
	end

	assign ptr_next = (ptr == SENSOR_W'(SENSOR_COUNT - 1)) ? '0 : ptr + 1'b1;
	assign gap_done = (gap_cnt == GAP_CNT_W'(PING_GAP_CYCLES - 1));

	// ------------------------------------------------------------
	// Grant sequencing
	// ------------------------------------------------------------
	always_ff @(posedge CLOCK_50 or negedge reset) begin
		if (!reset) begin
			grant_vec <= '0;
			ptr <= '0;
			gap_cnt <= '0;
		end else if (|grant_vec) begin
			// Ping in flight, release on its valid
			if (valid_vec[ptr]) begin
				grant_vec <= '0;
				gap_cnt <= '0;
				ptr <= ptr_next;
			end
		end else if (gap_done) begin
			// Channel quiet long enough
			grant_vec <= SENSOR_COUNT'(1) << ptr;
			gap_cnt <= '0;
		end else begin
			gap_cnt <= gap_cnt + 1'b1;
		end
	end

endmodule

/* source/obstacle_detect.sv */
module obstacle_detect import proximity_pkg::*; #(
	parameter int unsigned THRESHOLD_MM = 1000
) (
	input  logic CLOCK_50,
	input  logic reset,
	ping_bus_if.monitor result,
	output logic [DIST_W-1:0] latched_mm,
	output logic stop
);

	logic too_close;

	// Closer than the limit with a real echo
	assign too_close = !result.no_echo
		&& (result.distance_mm < DIST_W'(THRESHOLD_MM));

	// ------------------------------------------------------------
	// Latch on each completed ping
	// ------------------------------------------------------------
	always_ff @(posedge CLOCK_50 or negedge reset) begin
		if (!reset) begin
			latched_mm <= '0;
			stop <= 1'b0;
		end else if (result.valid) begin
			latched_mm <= result.distance_mm;
			// Clears again once the path is open
			stop <= too_close;
		end
	end

endmodule

/* source/hex_display.sv */
module hex_display import proximity_pkg::*; (
	input  logic CLOCK_50,
	input  logic reset,
	input  logic [DIST_W-1:0] value,
	output logic [6:0] digit0,
	output logic [6:0] digit1,
	output logic [6:0] digit2,
	output logic [6:0] digit3
);

	// BCD field above the binary field
	logic [DIST_W+15:0] shift;
	logic [15:0] bcd;

	// ------------------------------------------------------------
	// Double dabble, unrolled
	// ------------------------------------------------------------
	always_comb begin
		shift = '0;
		shift[DIST_W-1:0] = value;
		for (int i = 0; i < DIST_W; i++) begin
			// Add 3 to any digit of 5 or more
			for (int d = 0; d < 4; d++) begin
				if (shift[DIST_W + 4*d +: 4] >= 4'd5) begin
					shift[DIST_W + 4*d +: 4] = shift[DIST_W + 4*d +: 4] + 4'd3;
				end
			end
			shift = shift << 1;
		end
		bcd = shift[DIST_W +: 16];
	end

	// ------------------------------------------------------------
	// Segment registers
	// ------------------------------------------------------------
	always_ff @(posedge CLOCK_50 or negedge reset) begin
		if (!reset) begin
			// Show 0000 out of reset
			digit0 <= seg7(4'd0);
			digit1 <= seg7(4'd0);
			digit2 <= seg7(4'd0);
			digit3 <= seg7(4'd0);
		end else begin
			digit0 <= seg7(bcd[3:0]);
			digit1 <= seg7(bcd[7:4]);
			digit2 <= seg7(bcd[11:8]);
			digit3 <= seg7(bcd[15:12]);
		end
	end

endmodule

/* source/proximity_top.sv */
module proximity_top import proximity_pkg::*; (
	input  logic CLOCK_50,
	input  logic reset,
	input  logic echo_front,
	input  logic echo_back,
	output logic trig_front,
	output logic trig_back,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output logic [6:0] hex6,
	output logic [6:0] hex7,
	output logic [17:0] ledr
);

	// One bus per ranger, 0 front and 1 back
	ping_bus_if ping_bus [SENSOR_COUNT] ();

	logic [DIST_W-1:0] latched_front;
	logic [DIST_W-1:0] latched_back;
	logic stop_front;
	logic stop_back;

	// ------------------------------------------------------------
	// Rangers and channel arbitration
	// ------------------------------------------------------------
	sonar_range u_range_front (
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.echo     (echo_front),
		.trig     (trig_front),
		.bus      (ping_bus[0])
	);

	sonar_range u_range_back (
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.echo     (echo_back),
		.trig     (trig_back),
		.bus      (ping_bus[1])
	);

	ping_arbiter u_arbiter (
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.bus      (ping_bus)
	);

	// ------------------------------------------------------------
	// Obstacle flags, per-sensor limits
	// ------------------------------------------------------------
	obstacle_detect #(.THRESHOLD_MM(FRONT_THRESHOLD_MM)) u_detect_front (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.result     (ping_bus[0]),
		.latched_mm (latched_front),
		.stop       (stop_front)
	);

	obstacle_detect #(.THRESHOLD_MM(BACK_THRESHOLD_MM)) u_detect_back (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.result     (ping_bus[1]),
		.latched_mm (latched_back),
		.stop       (stop_back)
	);

	// ------------------------------------------------------------
	// Displays, low digit on hex0 and hex4
	// ------------------------------------------------------------
	hex_display u_display_front (
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.value    (latched_front),
		.digit0   (hex0),
		.digit1   (hex1),
		.digit2   (hex2),
		.digit3   (hex3)
	);

	hex_display u_display_back (
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.value    (latched_back),
		.digit0   (hex4),
		.digit1   (hex5),
		.digit2   (hex6),
		.digit3   (hex7)
	);

	// Status LEDs
	assign ledr[17] = stop_front;
	assign ledr[16] = stop_back;
	// Ping in progress on either sensor
	assign ledr[15] = ping_bus[0].grant | ping_bus[1].grant;
	assign ledr[14:0] = '0;

endmodule

/* verif/sonar_echo_model.sv */
module sonar_echo_model import proximity_pkg::*; #(
	// Echo width added on top of the exact distance
	parameter int unsigned ECHO_PAD = 100
) (
	input  logic CLOCK_50,
	input  logic trig,
	input  logic [DIST_W-1:0] distance_mm,
	input  logic silent,
	output logic echo
);

	// Flight delay range, 50 to 500 cycles
	localparam int unsigned DELAY_MIN = 50;
	localparam int unsigned DELAY_SPAN = 451;

	int unsigned delay_cycles;
	int unsigned width_cycles;
	logic quiet;

	// ------------------------------------------------------------
	// Answer each trigger pulse
	// ------------------------------------------------------------
	initial begin
		echo = 1'b0;
		forever begin
			// Full pulse only, reset settling is ignored
			@(posedge trig);
			@(negedge trig);
			// Programming captured at trigger fall
			quiet = silent;
			delay_cycles = DELAY_MIN + ($urandom % DELAY_SPAN);
			width_cycles = distance_mm * CYCLES_PER_MM + ECHO_PAD;
			if (!quiet) begin
				repeat (delay_cycles) @(negedge CLOCK_50);
				echo = 1'b1;
				repeat (width_cycles) @(negedge CLOCK_50);
				echo = 1'b0;
			end
		end
	end

endmodule

/* verif/tb_proximity.sv */
module tb_proximity import proximity_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int unsigned SEED = 32'h7c3f2bf4;
	// Six tests of four pings at up to 400000 cycles each
	localparam longint WATCHDOG_TIME = 64'd6 * 4 * 400000 * CLK_PERIOD;
	localparam int unsigned ECHO_MARGIN = 100;
	// Slack from echo fall to settled display
	localparam int SETTLE_CYCLES = 5;
	localparam time MIN_GAP_TIME = PING_GAP_CYCLES * CLK_PERIOD;
	localparam int FRONT = 0;
	localparam int BACK = 1;

	logic CLOCK_50;
	logic reset;
	logic echo_front;
	logic echo_back;
	logic trig_front;
	logic trig_back;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex4;
	logic [6:0] hex5;
	logic [6:0] hex6;
	logic [6:0] hex7;
	logic [17:0] ledr;

	// Echo model programming
	logic [DIST_W-1:0] front_mm;
	logic [DIST_W-1:0] back_mm;
	logic front_silent;
	logic back_silent;

	int mismatch_count;
	int other_count;
	time last_echo_fall;

	proximity_top u_dut (
		.CLOCK_50   (CLOCK_50),
		.reset      (reset),
		.echo_front (echo_front),
		.echo_back  (echo_back),
		.trig_front (trig_front),
		.trig_back  (trig_back),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2),
		.hex3       (hex3),
		.hex4       (hex4),
		.hex5       (hex5),
		.hex6       (hex6),
		.hex7       (hex7),
		.ledr       (ledr)
	);

	sonar_echo_model #(.ECHO_PAD(ECHO_MARGIN)) u_echo_front (
		.CLOCK_50    (CLOCK_50),
		.trig        (trig_front),
		.distance_mm (front_mm),
		.silent      (front_silent),
		.echo        (echo_front)
	);

	sonar_echo_model #(.ECHO_PAD(ECHO_MARGIN)) u_echo_back (
		.CLOCK_50    (CLOCK_50),
		.trig        (trig_back),
		.distance_mm (back_mm),
		.silent      (back_silent),
		.echo        (echo_back)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired before the tests finished");
		$display("Simulation FAILED");
		$finish;
	end

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	function automatic logic trig_of(input int sensor);
		return (sensor == FRONT) ? trig_front : trig_back;
	endfunction

	// Four decimal digits with thousands on the left
	function automatic logic [27:0] segments_for(input int unsigned mm);
		return {seg7(4'((mm / 1000) % 10)), seg7(4'((mm / 100) % 10)),
			seg7(4'((mm / 10) % 10)), seg7(4'(mm % 10))};
	endfunction

	task automatic check_display(input string name, input int sensor, input int unsigned mm);
		logic [27:0] expected;
		logic [27:0] actual;
		expected = segments_for(mm);
		actual = (sensor == FRONT) ? {hex3, hex2, hex1, hex0} : {hex7, hex6, hex5, hex4};
		if (actual !== expected) begin
			$display("mismatch %s: expected %07h actual %07h", name, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("mismatch %s: expected %b actual %b", name, expected, actual);
			mismatch_count++;
		end
	endtask

	// Trigger and echo of one sensor followed by settling
	task automatic wait_for_ping(input int sensor);
		logic silent;
		silent = (sensor == FRONT) ? front_silent : back_silent;
		while (trig_of(sensor) !== 1'b1) begin
			@(negedge CLOCK_50);
		end
		while (trig_of(sensor) !== 1'b0) begin
			@(negedge CLOCK_50);
		end
		if (silent) begin
			// Ranger gives up after the echo wait
			repeat (ECHO_WAIT_CYCLES) @(negedge CLOCK_50);
		end else if (sensor == FRONT) begin
			@(negedge echo_front);
		end else begin
			@(negedge echo_back);
		end
		last_echo_fall = $time;
		repeat (SETTLE_CYCLES) @(negedge CLOCK_50);
	endtask

	// ------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------
	task automatic test_reset();
		repeat (2) @(negedge CLOCK_50);
		if (trig_front !== 1'b0 || trig_back !== 1'b0) begin
			$display("A trigger is active right after reset");
			other_count++;
		end
		if (ledr !== 18'h0) begin
			$display("mismatch reset ledr: expected %05h actual %05h", 18'h0, ledr);
			mismatch_count++;
		end
		check_display("reset front display", FRONT, 0);
		check_display("reset back display", BACK, 0);
	endtask

	task automatic test_front_near();
		front_mm = 12'd300;
		wait_for_ping(FRONT);
		check_display("front near display", FRONT, 300);
		check_bit("front near stop", 1'b1, ledr[17]);
	endtask

	task automatic test_back_far();
		back_mm = 12'd800;
		wait_for_ping(BACK);
		check_display("back far display", BACK, 800);
		check_bit("back far stop", 1'b0, ledr[16]);
	endtask

	task automatic test_alternation();
		int expected_sensor;
		int seen;
		time gap;
		for (int k = 0; k < 3; k++) begin
			expected_sensor = (k % 2 == 0) ? FRONT : BACK;
			while (trig_front !== 1'b1 && trig_back !== 1'b1) begin
				@(negedge CLOCK_50);
			end
			seen = (trig_front === 1'b1) ? FRONT : BACK;
			if (seen != expected_sensor) begin
				$display("mismatch alternation: expected %0d actual %0d", expected_sensor, seen);
				mismatch_count++;
			end
			// Grant is held for the whole ping
			check_bit("alternation busy led", 1'b1, ledr[15]);
			gap = $time - last_echo_fall;
			if (gap < MIN_GAP_TIME) begin
				$display("Ping %0d started only %0t after the previous echo", k, gap);
				other_count++;
			end
			// Other trigger must stay quiet
			while (trig_of(seen) !== 1'b0) begin
				if (trig_of(1 - seen) !== 1'b0) begin
					$display("Both triggers high during ping %0d", k);
					other_count++;
				end
				@(negedge CLOCK_50);
			end
			if (seen == FRONT) begin
				@(negedge echo_front);
			end else begin
				@(negedge echo_back);
			end
			last_echo_fall = $time;
			repeat (SETTLE_CYCLES) @(negedge CLOCK_50);
			// Grant dropped after the valid
			check_bit("alternation idle led", 1'b0, ledr[15]);
		end
	endtask

	task automatic test_front_silent();
		front_silent = 1'b1;
		wait_for_ping(FRONT);
		check_display("front silent display", FRONT, MAX_RANGE_MM);
		check_bit("front silent stop", 1'b0, ledr[17]);
	endtask

	task automatic test_front_change();
		front_silent = 1'b0;
		front_mm = 12'd300;
		wait_for_ping(FRONT);
		check_bit("front change near stop", 1'b1, ledr[17]);
		check_display("front change near display", FRONT, 300);
		front_mm = 12'd1200;
		wait_for_ping(FRONT);
		check_bit("front change far stop", 1'b0, ledr[17]);
		check_display("front change far display", FRONT, 1200);
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin
		void'($urandom(SEED));
		reset = 1'b0;
		front_mm = '0;
		back_mm = '0;
		front_silent = 1'b0;
		back_silent = 1'b0;
		mismatch_count = 0;
		other_count = 0;
		last_echo_fall = 0;
		repeat (RESET_CYCLES) @(negedge CLOCK_50);
		reset = 1'b1;
		test_reset();
		test_front_near();
		test_back_far();
		test_alternation();
		test_front_silent();
		test_front_change();
		$display("Checks done: %0d mismatches, %0d other errors", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* compile.f */
source/proximity_pkg.sv
source/ping_bus_if.sv
source/sonar_range.sv
source/ping_arbiter.sv
source/obstacle_detect.sv
source/hex_display.sv
source/proximity_top.sv
verif/sonar_echo_model.sv
verif/tb_proximity.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_proximity -f compile.f -o sim_proximity \
	&& ./obj_dir/sim_proximity | tee /dev/stderr | grep -q "Simulation PASSED" \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail"; exit 1; }
